// ==== Makefile ====
# Verilator build for the fuse write filter testbench.

VERILATOR ?= verilator
TOP       ?= tb_fuse_filter
FLIST     ?= fuse_filter.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_fuse_filter.sv ====
// Runs with the default range and secret parameters; one AXI beat per cycle, no stalls.
`timescale 1ns/1ns

module tb_fuse_filter;

    localparam int CLK_HALF     = 50;
    localparam int RESET_CYCLES = 10;
    localparam fuse_filter_pkg::axi_user_t CPTRA_ID = 32'h0000_0C11;
    localparam fuse_filter_pkg::axi_user_t MCU_ID   = 32'h0000_0A55;
    localparam fuse_filter_pkg::axi_user_t ROGUE_ID = 32'h0000_0BAD;

    logic                        clk;
    logic                        rst_n;
    logic                        fc_init_done;
    logic                        fips_zeroize;
    logic                        discarded_fuse_write;
    logic                        discard_fuse_write;
    fuse_filter_pkg::axi_snoop_t snoop;

    int error_count;
    int test_count;
    int failed_tests;
    int test_errors_at_start;

    fuse_filter_top u_dut (
        .clk_i                  (clk),
        .rst_n_i                (rst_n),
        .fc_init_done_i         (fc_init_done),
        .fips_zeroize_i         (fips_zeroize),
        .cptra_user_i           (CPTRA_ID),
        .mcu_user_i             (MCU_ID),
        .snoop_i                (snoop),
        .discarded_fuse_write_i (discarded_fuse_write),
        .discard_fuse_write_o   (discard_fuse_write)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_HALF) clk = ~clk;

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_discard(input logic exp, input string what);
        if (discard_fuse_write !== exp) begin
            $display("[FAIL] discard_fuse_write_o (%s): got 0x%0h, expected 0x%0h",
                     what, discard_fuse_write, exp);
            error_count++;
        end
    endtask

    task automatic check_user_id(input fuse_filter_pkg::axi_user_t got,
                                 input fuse_filter_pkg::axi_user_t exp,
                                 input string name);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    // --------------------------------------------------
    // Bus drivers
    // --------------------------------------------------
    // Every driver starts just after a rising edge and ends just after one.
    task automatic axi_aw_beat(input fuse_filter_pkg::reg_offset_t offset,
                               input fuse_filter_pkg::axi_user_t user);
        snoop.aw_valid  <= 1'b1;
        snoop.aw_ready  <= 1'b1;
        snoop.aw_offset <= offset;
        snoop.aw_user   <= user;
        @(posedge clk);
        snoop.aw_valid <= 1'b0;
        snoop.aw_ready <= 1'b0;
    endtask

    task automatic axi_w_beat(input logic [31:0] data);
        snoop.w_valid <= 1'b1;
        snoop.w_ready <= 1'b1;
        snoop.w_data  <= data;
        @(posedge clk);
        snoop.w_valid <= 1'b0;
        snoop.w_ready <= 1'b0;
    endtask

    task automatic run_cmd_sequence(input logic with_data,
                                    input fuse_filter_pkg::axi_user_t data0_id,
                                    input fuse_filter_pkg::axi_user_t data1_id,
                                    input fuse_filter_pkg::axi_user_t addr_id,
                                    input fuse_filter_pkg::axi_user_t cmd_id,
                                    input fuse_filter_pkg::fuse_addr_t fuse_addr,
                                    input fuse_filter_pkg::dai_cmd_e cmd);
        if (with_data) begin
            axi_aw_beat(fuse_filter_pkg::WDATA0_OFFSET, data0_id);
            axi_w_beat($urandom);
            axi_aw_beat(fuse_filter_pkg::WDATA1_OFFSET, data1_id);
            axi_w_beat($urandom);
        end
        axi_aw_beat(fuse_filter_pkg::ADDR_OFFSET, addr_id);
        axi_w_beat(fuse_addr);
        axi_aw_beat(fuse_filter_pkg::CMD_OFFSET, cmd_id);
        axi_w_beat(cmd);
    endtask

    task automatic acknowledge_discard();
        discarded_fuse_write <= 1'b1;
        @(posedge clk);
        discarded_fuse_write <= 1'b0;
    endtask

    // --------------------------------------------------
    // Waits and per-cycle checks
    // --------------------------------------------------
    // Outputs are sampled at the falling edge, half a cycle away from any update.
    task automatic hold_discard_check(input logic exp, input int cycles, input string what);
        repeat (cycles) begin
            @(negedge clk);
            check_discard(exp, what);
        end
        @(posedge clk);
    endtask

    task automatic wait_discard_state(input logic exp, input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (discard_fuse_write !== exp && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (discard_fuse_write !== exp) begin
            $display("Timeout while %s: discard did not reach %0b within %0d cycles",
                     what, exp, limit);
            error_count++;
        end
        @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_errors_at_start) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - test_errors_at_start);
        end
        test_errors_at_start = error_count;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_init_gating();
        run_cmd_sequence(1'b1, MCU_ID, ROGUE_ID, MCU_ID, MCU_ID, 32'h150,
                         fuse_filter_pkg::DAI_WRITE);
        // Latches stay cleared while the controller is still initializing.
        check_user_id(u_dut.u_tracker.cmd_id_o, '0, "cmd_id before init");
        hold_discard_check(1'b0, 5, "before init done");
        fc_init_done <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        finish_test("init gating");
    endtask

    task automatic test_allowed_write();
        fuse_filter_pkg::fuse_addr_t addr;
        addr = 32'h100 + ($urandom % 32'h100);
        run_cmd_sequence(1'b1, MCU_ID, MCU_ID, MCU_ID, MCU_ID, addr,
                         fuse_filter_pkg::DAI_WRITE);
        check_user_id(u_dut.u_tracker.cmd_id_o, MCU_ID, "cmd_id");
        hold_discard_check(1'b0, 5, "allowed write");
        finish_test("allowed write");
    endtask

    task automatic test_id_mismatch();
        run_cmd_sequence(1'b1, MCU_ID, ROGUE_ID, MCU_ID, MCU_ID, 32'h180,
                         fuse_filter_pkg::DAI_WRITE);
        check_user_id(u_dut.u_tracker.cmd_id_o, MCU_ID, "cmd_id");
        hold_discard_check(1'b1, 4, "data1 ID mismatch, before ack");
        acknowledge_discard();
        wait_discard_state(1'b0, 3, "releasing after ack");
        finish_test("ID mismatch");
    endtask

    task automatic test_range_violation();
        fuse_filter_pkg::fuse_addr_t addr;
        addr = $urandom % 32'h100;
        run_cmd_sequence(1'b0, '0, '0, MCU_ID, MCU_ID, addr, fuse_filter_pkg::DAI_DIGEST);
        hold_discard_check(1'b1, 1, "digest of range 0 by MCU");
        acknowledge_discard();
        wait_discard_state(1'b0, 3, "releasing after ack");
        run_cmd_sequence(1'b0, '0, '0, MCU_ID, MCU_ID, addr, fuse_filter_pkg::DAI_READ);
        hold_discard_check(1'b0, 3, "read of range 0 by MCU");
        finish_test("range violation");
    endtask

    task automatic test_secret_zeroize();
        run_cmd_sequence(1'b0, '0, '0, CPTRA_ID, CPTRA_ID, 32'h040,
                         fuse_filter_pkg::DAI_ZEROIZE);
        check_user_id(u_dut.u_tracker.cmd_id_o, CPTRA_ID, "cmd_id");
        hold_discard_check(1'b1, 1, "secret zeroize without FIPS");
        acknowledge_discard();
        wait_discard_state(1'b0, 3, "releasing after ack");
        fips_zeroize <= 1'b1;
        run_cmd_sequence(1'b0, '0, '0, CPTRA_ID, CPTRA_ID, 32'h040,
                         fuse_filter_pkg::DAI_ZEROIZE);
        hold_discard_check(1'b0, 3, "secret zeroize under FIPS");
        fips_zeroize <= 1'b0;
        finish_test("secret zeroize");
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        error_count          = 0;
        test_count           = 0;
        failed_tests         = 0;
        test_errors_at_start = 0;
        void'($urandom(32'h19d9091c));

        rst_n                <= 1'b0;
        fc_init_done         <= 1'b0;
        fips_zeroize         <= 1'b0;
        discarded_fuse_write <= 1'b0;
        snoop                <= '0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_init_gating();
        test_allowed_write();
        test_id_mismatch();
        test_range_violation();
        test_secret_zeroize();

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== common/fuse_filter_pkg.sv ====
// Command values and register offsets are this filter's own encoding; offsets assume a 4 KiB window.
package fuse_filter_pkg;

    // --------------------------------------------------
    // Widths that carry a meaning
    // --------------------------------------------------
    typedef logic [31:0] fuse_addr_t;
    typedef logic [31:0] axi_user_t;
    typedef logic [11:0] reg_offset_t;

    // Direct-access registers of the fuse controller.
    localparam reg_offset_t WDATA0_OFFSET = 12'h010;
    localparam reg_offset_t WDATA1_OFFSET = 12'h014;
    localparam reg_offset_t ADDR_OFFSET   = 12'h018;
    localparam reg_offset_t CMD_OFFSET    = 12'h01C;

    // Range 0 pairs with the Caliptra ID, ranges 1 and 2 with the MCU ID.
    localparam int NUM_RANGES = 3;

    // Any value outside this list is an unknown command.
    typedef enum logic [31:0] {
        DAI_READ    = 32'h0000_0001,
        DAI_WRITE   = 32'h0000_0002,
        DAI_DIGEST  = 32'h0000_0004,
        DAI_ZEROIZE = 32'h0000_0008
    } dai_cmd_e;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        WDATA_ADDR,
        WDATA,
        FADDR_ADDR,
        FADDR_WR,
        CMD_ADDR,
        DISCARD
    } seq_state_e;

    // --------------------------------------------------
    // Bundles between blocks
    // --------------------------------------------------
    // Observed AXI write channel fields, read only.
    typedef struct packed {
        logic        aw_valid;
        logic        aw_ready;
        reg_offset_t aw_offset;
        axi_user_t   aw_user;
        logic        w_valid;
        logic        w_ready;
        logic [31:0] w_data;
    } axi_snoop_t;

    typedef struct packed {
        logic wdata0_aw;
        logic wdata1_aw;
        logic addr_aw;
        logic cmd_aw;
        logic w_beat;
    } phase_evt_t;

    typedef struct packed {
        logic clear;
        logic lat_data0;
        logic lat_data1;
        logic lat_addr_id;
        logic lat_cmd_id;
        logic lat_fuse_addr;
    } latch_ctrl_t;

endpackage

// ==== design/fuse_filter_top.sv ====
// Observes AXI only; the fuse controller must honour discard_fuse_write_o and acknowledge it.
`timescale 1ns/1ns

module fuse_filter_top #(
    parameter fuse_filter_pkg::fuse_addr_t RANGE0_LO = 32'h0000_0000,
    parameter fuse_filter_pkg::fuse_addr_t RANGE0_HI = 32'h0000_00FF,
    parameter fuse_filter_pkg::fuse_addr_t RANGE1_LO = 32'h0000_0100,
    parameter fuse_filter_pkg::fuse_addr_t RANGE1_HI = 32'h0000_01FF,
    parameter fuse_filter_pkg::fuse_addr_t RANGE2_LO = 32'h0000_0200,
    parameter fuse_filter_pkg::fuse_addr_t RANGE2_HI = 32'h0000_02FF,
    parameter fuse_filter_pkg::fuse_addr_t SECRET_LO = 32'h0000_0000,
    parameter fuse_filter_pkg::fuse_addr_t SECRET_HI = 32'h0000_007F
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         fc_init_done_i,
    input  logic                         fips_zeroize_i,
    input  fuse_filter_pkg::axi_user_t   cptra_user_i,
    input  fuse_filter_pkg::axi_user_t   mcu_user_i,
    input  fuse_filter_pkg::axi_snoop_t  snoop_i,
    input  logic                         discarded_fuse_write_i,
    output logic                         discard_fuse_write_o
);

    fuse_filter_pkg::phase_evt_t  evt;
    fuse_filter_pkg::latch_ctrl_t ctrl;
    fuse_filter_pkg::fuse_addr_t  fuse_addr;
    fuse_filter_pkg::axi_user_t   cmd_id;
    fuse_filter_pkg::dai_cmd_e    cmd;
    logic                         secret;
    logic                         all_same_id;
    logic                         addr_cmd_same_id;
    logic                         write_allowed;

    dai_id_tracker #(
        .SECRET_LO (SECRET_LO),
        .SECRET_HI (SECRET_HI)
    ) u_tracker (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .snoop_i            (snoop_i),
        .ctrl_i             (ctrl),
        .evt_o              (evt),
        .fuse_addr_o        (fuse_addr),
        .cmd_id_o           (cmd_id),
        .secret_o           (secret),
        .all_same_id_o      (all_same_id),
        .addr_cmd_same_id_o (addr_cmd_same_id),
        .cmd_o              (cmd)
    );

    fuse_range_table #(
        .RANGE0_LO (RANGE0_LO),
        .RANGE0_HI (RANGE0_HI),
        .RANGE1_LO (RANGE1_LO),
        .RANGE1_HI (RANGE1_HI),
        .RANGE2_LO (RANGE2_LO),
        .RANGE2_HI (RANGE2_HI)
    ) u_table (
        .fuse_addr_i     (fuse_addr),
        .cmd_id_i        (cmd_id),
        .cptra_user_i    (cptra_user_i),
        .mcu_user_i      (mcu_user_i),
        .write_allowed_o (write_allowed)
    );

    dai_cmd_sequencer u_seq (
        .clk_i                  (clk_i),
        .rst_n_i                (rst_n_i),
        .fc_init_done_i         (fc_init_done_i),
        .fips_zeroize_i         (fips_zeroize_i),
        .evt_i                  (evt),
        .cmd_i                  (cmd),
        .write_allowed_i        (write_allowed),
        .all_same_id_i          (all_same_id),
        .addr_cmd_same_id_i     (addr_cmd_same_id),
        .secret_i               (secret),
        .discarded_fuse_write_i (discarded_fuse_write_i),
        .ctrl_o                 (ctrl),
        .discard_fuse_write_o   (discard_fuse_write_o)
    );

endmodule

// ==== filter/dai_cmd_sequencer.sv ====
// One command is tracked at a time; the discard holds until the controller acknowledges it.
`timescale 1ns/1ns

module dai_cmd_sequencer (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         fc_init_done_i,
    input  logic                         fips_zeroize_i,
    input  fuse_filter_pkg::phase_evt_t  evt_i,
    input  fuse_filter_pkg::dai_cmd_e    cmd_i,
    input  logic                         write_allowed_i,
    input  logic                         all_same_id_i,
    input  logic                         addr_cmd_same_id_i,
    input  logic                         secret_i,
    input  logic                         discarded_fuse_write_i,
    output fuse_filter_pkg::latch_ctrl_t ctrl_o,
    output logic                         discard_fuse_write_o
);

    fuse_filter_pkg::seq_state_e state_q;
    fuse_filter_pkg::seq_state_e state_d;
    logic                        violation;
    logic                        discard_d;

    // --------------------------------------------------
    // Per-command policy
    // --------------------------------------------------
    // Read and unknown commands are never discarded.
    always_comb begin
        case (cmd_i)
            fuse_filter_pkg::DAI_WRITE: begin
                violation = !write_allowed_i || !all_same_id_i;
            end
            fuse_filter_pkg::DAI_DIGEST: begin
                violation = !write_allowed_i || !addr_cmd_same_id_i;
            end
            fuse_filter_pkg::DAI_ZEROIZE: begin
                // The secret range may only be zeroized under a FIPS zeroization.
                violation = (secret_i && !fips_zeroize_i) ||
                            !write_allowed_i ||
                            !addr_cmd_same_id_i;
            end
            default: begin
                violation = 1'b0;
            end
        endcase
    end

    // --------------------------------------------------
    // Phase FSM
    // --------------------------------------------------
    always_comb begin
        state_d   = state_q;
        ctrl_o    = '0;
        discard_d = 1'b0;

        case (state_q)
            fuse_filter_pkg::RESET: begin
                ctrl_o.clear = 1'b1;
                if (fc_init_done_i) begin
                    state_d = fuse_filter_pkg::IDLE;
                end
            end
            // A new register write may start from any settled phase.
            fuse_filter_pkg::IDLE,
            fuse_filter_pkg::WDATA,
            fuse_filter_pkg::FADDR_WR: begin
                if (evt_i.wdata0_aw) begin
                    ctrl_o.lat_data0 = 1'b1;
                    state_d          = fuse_filter_pkg::WDATA_ADDR;
                end else if (evt_i.wdata1_aw) begin
                    ctrl_o.lat_data1 = 1'b1;
                    state_d          = fuse_filter_pkg::WDATA_ADDR;
                end else if (evt_i.addr_aw) begin
                    ctrl_o.lat_addr_id = 1'b1;
                    state_d            = fuse_filter_pkg::FADDR_ADDR;
                end else if (evt_i.cmd_aw) begin
                    ctrl_o.lat_cmd_id = 1'b1;
                    state_d           = fuse_filter_pkg::CMD_ADDR;
                end
            end
            fuse_filter_pkg::WDATA_ADDR: begin
                if (evt_i.w_beat) begin
                    state_d = fuse_filter_pkg::WDATA;
                end
            end
            fuse_filter_pkg::FADDR_ADDR: begin
                if (evt_i.w_beat) begin
                    ctrl_o.lat_fuse_addr = 1'b1;
                    state_d              = fuse_filter_pkg::FADDR_WR;
                end
            end
            fuse_filter_pkg::CMD_ADDR: begin
                // The W beat carries the command value itself.
                if (evt_i.w_beat) begin
                    discard_d = violation;
                    state_d   = violation ? fuse_filter_pkg::DISCARD : fuse_filter_pkg::IDLE;
                end
            end
            fuse_filter_pkg::DISCARD: begin
                discard_d = 1'b1;
                if (discarded_fuse_write_i) begin
                    state_d = fuse_filter_pkg::IDLE;
                end
            end
            default: begin
                state_d = fuse_filter_pkg::IDLE;
            end
        endcase
    end

    // The discard output is registered, so it lags its deciding beat by one cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q              <= fuse_filter_pkg::RESET;
            discard_fuse_write_o <= 1'b0;
        end else begin
            state_q              <= state_d;
            discard_fuse_write_o <= discard_d;
        end
    end

endmodule

// ==== filter/dai_id_tracker.sv ====
// A beat counts only with valid and ready high together; offsets are compared on 12 bits only.
`timescale 1ns/1ns

module dai_id_tracker #(
    parameter fuse_filter_pkg::fuse_addr_t SECRET_LO = 32'h0000_0000,
    parameter fuse_filter_pkg::fuse_addr_t SECRET_HI = 32'h0000_007F
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  fuse_filter_pkg::axi_snoop_t  snoop_i,
    input  fuse_filter_pkg::latch_ctrl_t ctrl_i,
    output fuse_filter_pkg::phase_evt_t  evt_o,
    output fuse_filter_pkg::fuse_addr_t  fuse_addr_o,
    output fuse_filter_pkg::axi_user_t   cmd_id_o,
    output logic                         secret_o,
    output logic                         all_same_id_o,
    output logic                         addr_cmd_same_id_o,
    output fuse_filter_pkg::dai_cmd_e    cmd_o
);

    logic                        aw_hs;
    logic                        in_secret;
    fuse_filter_pkg::axi_user_t  data0_id_q;
    fuse_filter_pkg::axi_user_t  data1_id_q;
    fuse_filter_pkg::axi_user_t  addr_id_q;
    fuse_filter_pkg::axi_user_t  cmd_id_q;
    fuse_filter_pkg::fuse_addr_t fuse_addr_q;
    logic                        secret_q;

    // --------------------------------------------------
    // Beat decode
    // --------------------------------------------------
    assign aw_hs = snoop_i.aw_valid && snoop_i.aw_ready;

    always_comb begin
        evt_o.wdata0_aw = aw_hs && (snoop_i.aw_offset == fuse_filter_pkg::WDATA0_OFFSET);
        evt_o.wdata1_aw = aw_hs && (snoop_i.aw_offset == fuse_filter_pkg::WDATA1_OFFSET);
        evt_o.addr_aw   = aw_hs && (snoop_i.aw_offset == fuse_filter_pkg::ADDR_OFFSET);
        evt_o.cmd_aw    = aw_hs && (snoop_i.aw_offset == fuse_filter_pkg::CMD_OFFSET);
        evt_o.w_beat    = snoop_i.w_valid && snoop_i.w_ready;
    end

    // The W data of an address write is the fuse address.
    assign in_secret = (snoop_i.w_data >= SECRET_LO) && (snoop_i.w_data <= SECRET_HI);

    // --------------------------------------------------
    // ID and address latches
    // --------------------------------------------------
    // Each enable arrives from the sequencer in the cycle of its beat, so the
    // latch is written on the same edge that samples the beat.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data0_id_q  <= '0;
            data1_id_q  <= '0;
            addr_id_q   <= '0;
            cmd_id_q    <= '0;
            fuse_addr_q <= '0;
            secret_q    <= 1'b0;
        end else if (ctrl_i.clear) begin
            data0_id_q  <= '0;
            data1_id_q  <= '0;
            addr_id_q   <= '0;
            cmd_id_q    <= '0;
            fuse_addr_q <= '0;
            secret_q    <= 1'b0;
        end else begin
            if (ctrl_i.lat_data0) begin
                data0_id_q <= snoop_i.aw_user;
            end
            if (ctrl_i.lat_data1) begin
                data1_id_q <= snoop_i.aw_user;
            end
            if (ctrl_i.lat_addr_id) begin
                addr_id_q <= snoop_i.aw_user;
            end
            if (ctrl_i.lat_cmd_id) begin
                cmd_id_q <= snoop_i.aw_user;
            end
            if (ctrl_i.lat_fuse_addr) begin
                fuse_addr_q <= snoop_i.w_data;
                secret_q    <= in_secret;
            end
        end
    end

    // --------------------------------------------------
    // Results to the table and the sequencer
    // --------------------------------------------------
    assign fuse_addr_o = fuse_addr_q;
    assign cmd_id_o    = cmd_id_q;
    assign secret_o    = secret_q;

    // A Write must come from one master across all four phases.
    assign all_same_id_o = (data0_id_q == data1_id_q) &&
                           (data1_id_q == addr_id_q) &&
                           (addr_id_q == cmd_id_q);

    assign addr_cmd_same_id_o = (addr_id_q == cmd_id_q);

    // Only meaningful while the command W beat is on the bus.
    assign cmd_o = fuse_filter_pkg::dai_cmd_e'(snoop_i.w_data);

endmodule

// ==== filter/fuse_range_table.sv ====
// Bounds are inclusive; ranges may overlap and any matching range grants the write.
`timescale 1ns/1ns

module fuse_range_table #(
    parameter fuse_filter_pkg::fuse_addr_t RANGE0_LO = 32'h0000_0000,
    parameter fuse_filter_pkg::fuse_addr_t RANGE0_HI = 32'h0000_00FF,
    parameter fuse_filter_pkg::fuse_addr_t RANGE1_LO = 32'h0000_0100,
    parameter fuse_filter_pkg::fuse_addr_t RANGE1_HI = 32'h0000_01FF,
    parameter fuse_filter_pkg::fuse_addr_t RANGE2_LO = 32'h0000_0200,
    parameter fuse_filter_pkg::fuse_addr_t RANGE2_HI = 32'h0000_02FF
) (
    input  fuse_filter_pkg::fuse_addr_t fuse_addr_i,
    input  fuse_filter_pkg::axi_user_t  cmd_id_i,
    input  fuse_filter_pkg::axi_user_t  cptra_user_i,
    input  fuse_filter_pkg::axi_user_t  mcu_user_i,
    output logic                        write_allowed_o
);

    localparam int NR = fuse_filter_pkg::NUM_RANGES;

    localparam fuse_filter_pkg::fuse_addr_t [NR-1:0] RANGE_LO = {RANGE2_LO, RANGE1_LO, RANGE0_LO};
    localparam fuse_filter_pkg::fuse_addr_t [NR-1:0] RANGE_HI = {RANGE2_HI, RANGE1_HI, RANGE0_HI};

    fuse_filter_pkg::axi_user_t [NR-1:0] range_id;
    logic [NR-1:0]                       range_hit;

    // --------------------------------------------------
    // Strap pairing and range match
    // --------------------------------------------------
    always_comb begin
        range_id[0] = cptra_user_i;
        range_id[1] = mcu_user_i;
        range_id[2] = mcu_user_i;

        for (int i = 0; i < NR; i++) begin
            range_hit[i] = (fuse_addr_i >= RANGE_LO[i]) &&
                           (fuse_addr_i <= RANGE_HI[i]) &&
                           (cmd_id_i == range_id[i]);
        end
    end

    assign write_allowed_o = |range_hit;

endmodule

// ==== fuse_filter.f ====
common/fuse_filter_pkg.sv
filter/dai_id_tracker.sv
filter/fuse_range_table.sv
filter/dai_cmd_sequencer.sv
design/fuse_filter_top.sv
bench/tb_fuse_filter.sv
